//--- cpu7_exu.f
rtl/exu_pkg.sv
rtl/exu_regfile.sv
rtl/exu_alu.sv
rtl/exu_branch.sv
rtl/exu_ecl.sv
rtl/cpu7_exu.sv
testbench/cpu7_exu_sva.sv
testbench/cpu7_exu_tb.sv

//--- rtl/cpu7_exu.sv
module cpu7_exu
   import exu_pkg::*;
(
   input  logic       clk,
   input  logic       reset,

   // issue slot from decode
   input  exu_issue_t issue,

   // decode stage register reads
   input  reg_addr_t  rs1_d,
   input  reg_addr_t  rs2_d,
   output word_t      rs1_data_d,
   output word_t      rs2_data_d,

   // redirect to fetch
   output br_result_t br
);

   word_t      alu_res;
   br_result_t bru_res;
   word_t      link_pc;
   wb_t        wb;

   exu_ecl ecl (
      .clk     (clk),
      .reset   (reset),
      .issue   (issue),
      .alu_res (alu_res),
      .bru_res (bru_res),
      .link_pc (link_pc),
      .br      (br),
      .wb      (wb)
   );

   exu_alu alu (
      .alu_op (issue.alu_op),
      .a      (issue.alu_a),
      .b      (issue.alu_b),
      .result (alu_res)
   );

   // compares use the alu operands
   exu_branch bru (
      .bru_op  (issue.bru_op),
      .a       (issue.alu_a),
      .b       (issue.alu_b),
      .pc      (issue.pc),
      .offset  (issue.bru_offset),
      .res     (bru_res),
      .link_pc (link_pc)
   );

   exu_regfile registers (
      .clk    (clk),
      .reset  (reset),
      .wb     (wb),
      .raddr0 (rs1_d),
      .raddr1 (rs2_d),
      .rdata0 (rs1_data_d),
      .rdata1 (rs2_data_d)
   );

endmodule

//--- rtl/exu_alu.sv
module exu_alu
   import exu_pkg::*;
(
   input  alu_op_t alu_op,
   input  word_t   a,
   input  word_t   b,
   output word_t   result
);

   logic [shamt_bits-1:0] shamt;
   word_t                 sum;
   word_t                 diff;
   logic                  lt_signed;
   logic                  lt_unsigned;

   assign shamt       = b[shamt_bits-1:0];
   assign sum         = a + b;
   assign diff        = a - b;
   assign lt_signed   = $signed(a) < $signed(b);
   assign lt_unsigned = a < b;

   always_comb begin
      case (alu_op)
         alu_add: begin
            result = sum;
         end
         alu_sub: begin
            result = diff;
         end
         // compares return 0 or 1
         alu_slt: begin
            result = word_t'(lt_signed);
         end
         alu_sltu: begin
            result = word_t'(lt_unsigned);
         end
         alu_and: begin
            result = a & b;
         end
         alu_or: begin
            result = a | b;
         end
         alu_xor: begin
            result = a ^ b;
         end
         alu_nor: begin
            result = ~(a | b);
         end
         alu_sll: begin
            result = a << shamt;
         end
         alu_srl: begin
            result = a >> shamt;
         end
         // sign fill from bit 31
         alu_sra: begin
            result = word_t'($signed(a) >>> shamt);
         end
         // lui path, immediate already in b
         alu_passb: begin
            result = b;
         end
         default: begin
            result = '0;
         end
      endcase
   end

endmodule

//--- rtl/exu_branch.sv
module exu_branch
   import exu_pkg::*;
(
   input  bru_op_t    bru_op,
   input  word_t      a,
   input  word_t      b,
   input  word_t      pc,
   input  word_t      offset,
   output br_result_t res,
   output word_t      link_pc
);

   logic  eq;
   logic  lt_signed;
   logic  lt_unsigned;
   logic  cond;
   word_t pc_target;
   word_t reg_target;

   assign eq          = a == b;
   assign lt_signed   = $signed(a) < $signed(b);
   assign lt_unsigned = a < b;

   // pc relative for the conditionals, b and bl
   assign pc_target  = pc + offset;
   // jirl jumps relative to the register operand
   assign reg_target = a + offset;

   always_comb begin
      case (bru_op)
         bru_beq: begin
            cond = eq;
         end
         bru_bne: begin
            cond = ~eq;
         end
         bru_blt: begin
            cond = lt_signed;
         end
         bru_bge: begin
            cond = ~lt_signed;
         end
         bru_bltu: begin
            cond = lt_unsigned;
         end
         bru_bgeu: begin
            cond = ~lt_unsigned;
         end
         // unconditional
         bru_b, bru_bl, bru_jirl: begin
            cond = 1'b1;
         end
         default: begin
            cond = 1'b0;
         end
      endcase
   end

   assign res.taken  = cond;
   assign res.target = (bru_op == bru_jirl) ? reg_target : pc_target;
   assign link_pc    = pc + link_offset;

endmodule

//--- rtl/exu_ecl.sv
module exu_ecl
   import exu_pkg::*;
(
   input  logic       clk,
   input  logic       reset,

   input  exu_issue_t issue,

   // results of the E stage datapath
   input  word_t      alu_res,
   input  br_result_t bru_res,
   input  word_t      link_pc,

   output br_result_t br,
   output wb_t        wb
);

   logic      link_sel;
   logic      wen_e;
   word_t     data_e;

   logic      wen_w;
   reg_addr_t rd_w;
   word_t     data_w;

   // redirect only for a live slot
   assign br.taken  = issue.valid & bru_res.taken;
   assign br.target = bru_res.target;

   // bl and jirl write the return address instead of the alu result
   assign link_sel = (issue.bru_op == bru_bl) || (issue.bru_op == bru_jirl);
   assign data_e   = link_sel ? link_pc : alu_res;

   // writes to r0 are dropped here
   assign wen_e = issue.valid & issue.wen & (issue.rd != '0);

   // W stage
   always_ff @(posedge clk) begin
      if (reset) begin
         wen_w <= 1'b0;
      end else begin
         wen_w <= wen_e;
      end
   end

   // payload only moves when a write is coming
   always_ff @(posedge clk) begin
      if (wen_e) begin
         rd_w   <= issue.rd;
         data_w <= data_e;
      end
   end

   assign wb.wen  = wen_w;
   assign wb.rd   = rd_w;
   assign wb.data = data_w;

endmodule

//--- rtl/exu_pkg.sv
package exu_pkg;

   // machine word and register file geometry
   localparam int grlen        = 32;
   localparam int rf_addr_bits = 5;
   localparam int rf_depth     = 1 << rf_addr_bits;

   // shift amount comes from the low bits of operand b
   localparam int shamt_bits   = 5;

   typedef logic [grlen-1:0]        word_t;
   typedef logic [rf_addr_bits-1:0] reg_addr_t;

   // link address is the next sequential instruction
   localparam word_t link_offset = word_t'(4);

   typedef enum logic [3:0] {
      alu_add   = 4'd0,
      alu_sub   = 4'd1,
      alu_slt   = 4'd2,
      alu_sltu  = 4'd3,
      alu_and   = 4'd4,
      alu_or    = 4'd5,
      alu_xor   = 4'd6,
      alu_nor   = 4'd7,
      alu_sll   = 4'd8,
      alu_srl   = 4'd9,
      alu_sra   = 4'd10,
      alu_passb = 4'd11
   } alu_op_t;

   typedef enum logic [3:0] {
      bru_none  = 4'd0,
      bru_beq   = 4'd1,
      bru_bne   = 4'd2,
      bru_blt   = 4'd3,
      bru_bge   = 4'd4,
      bru_bltu  = 4'd5,
      bru_bgeu  = 4'd6,
      bru_b     = 4'd7,
      bru_bl    = 4'd8,
      bru_jirl  = 4'd9
   } bru_op_t;

   // one issue slot from decode
   typedef struct packed {
      logic      valid;
      alu_op_t   alu_op;
      word_t     alu_a;
      word_t     alu_b;
      bru_op_t   bru_op;
      word_t     bru_offset;
      word_t     pc;
      reg_addr_t rd;
      logic      wen;
   } exu_issue_t;

   typedef struct packed {
      logic  taken;
      word_t target;
   } br_result_t;

   // one register file write
   typedef struct packed {
      logic      wen;
      reg_addr_t rd;
      word_t     data;
   } wb_t;

endpackage

//--- rtl/exu_regfile.sv
module exu_regfile
   import exu_pkg::*;
(
   input  logic      clk,
   input  logic      reset,

   // write port, fed from the W stage
   input  wb_t       wb,

   // decode stage read ports
   input  reg_addr_t raddr0,
   input  reg_addr_t raddr1,
   output word_t     rdata0,
   output word_t     rdata1
);

   word_t regs [rf_depth];

   // entry 0 never sees a write, so it stays zero after reset
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < rf_depth; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.wen) begin
         regs[wb.rd] <= wb.data;
      end
   end

   // no bypass from W, the new value shows after the write edge
   assign rdata0 = regs[raddr0];
   assign rdata1 = regs[raddr1];

endmodule

//--- testbench/cpu7_exu_sva.sv
module cpu7_exu_sva
   import exu_pkg::*;
(
   input logic       clk,
   input logic       reset,
   input exu_issue_t issue,
   input reg_addr_t  rs1_d,
   input reg_addr_t  rs2_d,
   input word_t      rs1_data_d,
   input word_t      rs2_data_d,
   input br_result_t br
);

   // redirect only for a live slot
   taken_needs_valid: assert property (@(posedge clk) disable iff (reset)
      !issue.valid |-> !br.taken)
      else $error("br.taken high without a valid issue slot");

   // r0 on either read port
   rs1_r0_zero: assert property (@(posedge clk) disable iff (reset)
      (rs1_d == '0) |-> (rs1_data_d == '0))
      else $error("register 0 read nonzero on rs1");
   rs2_r0_zero: assert property (@(posedge clk) disable iff (reset)
      (rs2_d == '0) |-> (rs2_data_d == '0))
      else $error("register 0 read nonzero on rs2");

   quiet_after_reset: assert property (@(posedge clk) $fell(reset) |-> !br.taken)
      else $error("br.taken high in the first cycle after reset");

endmodule

bind cpu7_exu cpu7_exu_sva sva_inst (
   .clk        (clk),
   .reset      (reset),
   .issue      (issue),
   .rs1_d      (rs1_d),
   .rs2_d      (rs2_d),
   .rs1_data_d (rs1_data_d),
   .rs2_data_d (rs2_data_d),
   .br         (br)
);

//--- testbench/cpu7_exu_tb.sv
module cpu7_exu_tb
   import exu_pkg::*;
();

   localparam int clk_period   = 40;
   localparam int reset_cycles = 4;
   // time units allowed for one clock level change
   localparam int edge_timeout = 2 * clk_period;

   logic       clk;
   logic       reset;
   exu_issue_t issue;
   reg_addr_t  rs1_d;
   reg_addr_t  rs2_d;
   word_t      rs1_data_d;
   word_t      rs2_data_d;
   br_result_t br;

   cpu7_exu cpu7_exu_inst (
      .clk        (clk),
      .reset      (reset),
      .issue      (issue),
      .rs1_d      (rs1_d),
      .rs2_d      (rs2_d),
      .rs1_data_d (rs1_data_d),
      .rs2_data_d (rs2_data_d),
      .br         (br)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(clk_period / 2) clk = ~clk;
      end
   end

   task automatic abort_run();
      $display("*** FAILED ***");
      $fatal(1, "run stopped at the first failure");
   endtask

   // leave the current level first, then wait for clk to reach level
   task automatic wait_edge(input logic level, input string what);
      int waited;
      waited = 0;
      while (clk === level && waited <= edge_timeout) begin
         #1;
         waited++;
      end
      while (clk !== level && waited <= edge_timeout) begin
         #1;
         waited++;
      end
      if (waited > edge_timeout) begin
         $display("timed out waiting for the %s", what);
         abort_run();
      end
   endtask

   task automatic check_word(input word_t expected, input word_t actual, input string what);
      if (actual !== expected) begin
         $display("Error at time %0t: %s expected %h, got %h", $time, what, expected, actual);
         abort_run();
      end
   endtask

   // target is a don't care while not taken
   task automatic check_br(input br_result_t expected, input br_result_t actual,
                           input string what);
      if (actual.taken !== expected.taken ||
          (expected.taken && actual.target !== expected.target)) begin
         $display("Error at time %0t: %s expected taken %b target %h, got taken %b target %h",
                  $time, what, expected.taken, expected.target, actual.taken, actual.target);
         abort_run();
      end
   endtask

   task automatic run_slot(input exu_issue_t slot, input logic back_to_back,
                           input br_result_t exp_br, input word_t exp_data);
      wait_edge(1'b0, "falling edge to drive the slot");
      issue = slot;
      #1;
      check_br(exp_br, br, "branch result");
      wait_edge(1'b1, "rising edge that captures the slot");
      // back to back slots go straight on to the next line
      if (!back_to_back) begin
         wait_edge(1'b0, "falling edge to drive an idle slot");
         issue = '0;
         #1;
         check_br('0, br, "branch result of the idle slot");
         wait_edge(1'b1, "rising edge that writes the register file");
         wait_edge(1'b0, "falling edge to read back rd");
         rs1_d = slot.rd;
         rs2_d = slot.rd;
         #1;
         check_word(exp_data, rs1_data_d, "rs1 read of rd");
         check_word(exp_data, rs2_data_d, "rs2 read of rd");
      end
   endtask

   initial begin
      int         fd;
      int         fields;
      int         records;
      string      line;
      word_t      col [13];
      exu_issue_t slot;
      br_result_t exp_br;

      reset = 1'b1;
      issue = '0;
      rs1_d = '0;
      rs2_d = '0;
      records = 0;
      for (int i = 0; i < reset_cycles; i++) begin
         wait_edge(1'b1, "rising edge during reset");
      end
      wait_edge(1'b0, "falling edge that releases reset");
      reset = 1'b0;

      // whole register file reads zero on both ports
      for (int i = 0; i < rf_depth; i++) begin
         wait_edge(1'b0, "falling edge for the reset readback");
         rs1_d = reg_addr_t'(i);
         rs2_d = reg_addr_t'(rf_depth - 1 - i);
         #1;
         check_word('0, rs1_data_d, "rs1 read after reset");
         check_word('0, rs2_data_d, "rs2 read after reset");
         check_br('0, br, "branch result after reset");
      end

      fd = $fopen("testbench/exu_testdata.txt", "r");
      if (fd == 0) begin
         $display("could not open the test data file testbench/exu_testdata.txt");
         abort_run();
      end
      while ($fgets(line, fd) != 0) begin
         // skip comments and blank lines
         if (line.len() > 1 && line.getc(0) != "#") begin
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                             col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                             col[7], col[8], col[9], col[10], col[11], col[12]);
            if (fields != 13) begin
               $display("malformed line in the test data file: %s", line);
               abort_run();
            end
            slot.valid      = col[0][0];
            slot.alu_op     = alu_op_t'(col[1][3:0]);
            slot.alu_a      = col[2];
            slot.alu_b      = col[3];
            slot.bru_op     = bru_op_t'(col[4][3:0]);
            slot.bru_offset = col[5];
            slot.pc         = col[6];
            slot.rd         = reg_addr_t'(col[7]);
            slot.wen        = col[8][0];
            exp_br.taken    = col[10][0];
            exp_br.target   = col[11];
            run_slot(slot, col[9][0], exp_br, col[12]);
            records++;
         end
      end
      $fclose(fd);

      if (records == 0) begin
         $display("the test data file holds no issue slots");
         abort_run();
      end else begin
         $display("*** PASSED ***");
         $finish;
      end
   end

endmodule

//--- testbench/exu_testdata.txt
# hex columns: valid alu_op alu_a alu_b bru_op bru_offset pc rd wen back_to_back
#   exp_taken exp_target exp_rd_value (target compared only when taken)
1 0 00000005 00000007 0 00000000 1c000000 01 1 0 0 00000000 0000000c
1 1 00000003 00000005 0 00000000 1c000004 02 1 0 0 00000000 fffffffe
1 2 ffffffff 00000001 0 00000000 1c000008 03 1 0 0 00000000 00000001
1 3 ffffffff 00000001 0 00000000 1c00000c 04 1 0 0 00000000 00000000
1 3 00000001 ffffffff 0 00000000 1c000010 05 1 0 0 00000000 00000001
1 4 f0f0f0f0 ff00ff00 0 00000000 1c000014 06 1 0 0 00000000 f000f000
1 5 f0f0f0f0 ff00ff00 0 00000000 1c000018 07 1 0 0 00000000 fff0fff0
1 6 f0f0f0f0 ff00ff00 0 00000000 1c00001c 08 1 0 0 00000000 0ff00ff0
1 7 f0f0f0f0 ff00ff00 0 00000000 1c000020 09 1 0 0 00000000 000f000f
1 8 80000001 00000104 0 00000000 1c000024 0a 1 0 0 00000000 00000010
1 9 80000000 0000001f 0 00000000 1c000028 0b 1 0 0 00000000 00000001
1 a 80000000 0000001f 0 00000000 1c00002c 0c 1 0 0 00000000 ffffffff
1 a 80000000 00000024 0 00000000 1c000030 0f 1 0 0 00000000 f8000000
1 b 12345678 abcde000 0 00000000 1c000034 0e 1 0 0 00000000 abcde000
1 0 00000005 00000005 1 00000040 1c000100 01 0 0 1 1c000140 0000000c
1 0 00000005 00000006 1 00000040 1c000100 01 0 0 0 00000000 0000000c
1 0 00000005 00000006 2 00000040 1c000100 01 0 0 1 1c000140 0000000c
1 0 00000005 00000005 2 00000040 1c000100 01 0 0 0 00000000 0000000c
1 0 ffffffff 00000001 3 fffffff0 1c000100 01 0 0 1 1c0000f0 0000000c
1 0 00000001 ffffffff 3 fffffff0 1c000100 01 0 0 0 00000000 0000000c
1 0 00000001 ffffffff 4 fffffff0 1c000100 01 0 0 1 1c0000f0 0000000c
1 0 ffffffff 00000001 4 fffffff0 1c000100 01 0 0 0 00000000 0000000c
1 0 00000001 ffffffff 5 00000100 1c000100 01 0 0 1 1c000200 0000000c
1 0 ffffffff 00000001 5 00000100 1c000100 01 0 0 0 00000000 0000000c
1 0 ffffffff 00000001 6 00000100 1c000100 01 0 0 1 1c000200 0000000c
1 0 00000001 ffffffff 6 00000100 1c000100 01 0 0 0 00000000 0000000c
1 0 00000005 00000005 1 00000040 1c000100 10 1 0 1 1c000140 0000000a
1 0 00000001 00000002 7 00001000 1c000200 01 0 0 1 1c001200 0000000c
1 0 00000001 00000002 8 fffffe00 1c000300 11 1 0 1 1c000100 1c000304
1 0 1c008000 00000000 9 00000010 1c000400 12 1 0 1 1c008010 1c000404
1 0 00000001 00000002 0 00000000 1c000500 00 1 0 0 00000000 00000000
0 0 00000001 00000002 7 00000010 1c000600 01 1 0 0 00000000 0000000c
1 0 11111111 00000000 0 00000000 1c000700 13 1 1 0 00000000 11111111
1 0 22222222 00000000 0 00000000 1c000704 13 1 0 0 00000000 22222222
